//--- icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Word widths
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// Cache geometry, one instruction per line
`define ICACHE_SETS 16
`define ICACHE_WAYS 4

// Address field widths
`define ICACHE_OFFSET_W 2
`define ICACHE_INDEX_W 4
`define ICACHE_WAY_W 2
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// Credits held after reset
`define ICACHE_RSP_CREDITS 2
`define ICACHE_MEM_CREDITS 1

// Width of both credit counters
`define ICACHE_CRED_W 2

`endif

//--- icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_WAY_W-1:0]   way_t;
    typedef logic [`ICACHE_WAY_W-1:0]   age_t;    // 0 is most recently used

    typedef struct packed {
        tag_t                        tag;
        index_t                      index;
        logic [`ICACHE_OFFSET_W-1:0] offset;        // Byte offset, always 0 for fetches
    } addr_fields_t;

    // Fetch address, seen as a raw word or split into fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    // Fetch side
    input  logic                      req_valid_i,
    input  icache_pkg::addr_u         req_addr_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output logic [`ICACHE_DATA_W-1:0] rsp_instr_o,
    output logic                      rsp_hit_o,
    input  logic                      rsp_credit_i,
    // Memory side
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    input  logic                      mem_rsp_valid_i,
    input  logic [`ICACHE_DATA_W-1:0] mem_rsp_data_i,
    input  logic                      mem_credit_i,
    // Array side
    output icache_pkg::index_t        lkp_index_o,
    output icache_pkg::tag_t          lkp_tag_o,
    input  logic                      hit_i,
    input  icache_pkg::way_t          hit_way_i,
    input  logic                      has_free_i,
    input  icache_pkg::way_t          free_way_i,
    input  logic [`ICACHE_DATA_W-1:0] hit_data_i,
    input  icache_pkg::way_t          victim_way_i,
    output logic                      fill_o,
    output icache_pkg::way_t          fill_way_o,
    output logic [`ICACHE_DATA_W-1:0] fill_data_o,
    output logic                      touch_o,
    output icache_pkg::way_t          touch_way_o
);

    icache_pkg::ctrl_state_e   state_q;
    icache_pkg::ctrl_state_e   state_d;
    icache_pkg::addr_u         addr_q;         // Accepted fetch address
    icache_pkg::way_t          fill_way_q;
    logic [`ICACHE_CRED_W-1:0] rsp_cred_q;
    logic [`ICACHE_CRED_W-1:0] mem_cred_q;
    logic                      rsp_valid_q;
    logic [`ICACHE_DATA_W-1:0] rsp_instr_q;
    logic                      rsp_hit_q;
    logic                      take;
    logic                      in_lookup;

    // Low while in reset
    assign req_ready_o = arst_n_i && (state_q == icache_pkg::IDLE) && (rsp_cred_q != '0);
    assign take        = req_valid_i && req_ready_o;
    assign in_lookup   = (state_q == icache_pkg::LOOKUP);

    assign lkp_index_o = addr_q.f.index;
    assign lkp_tag_o   = addr_q.f.tag;

    assign mem_req_o  = (state_q == icache_pkg::MISS_REQ) && (mem_cred_q != '0);
    assign mem_addr_o = addr_q.raw;

    assign fill_o      = (state_q == icache_pkg::MISS_WAIT) && mem_rsp_valid_i;
    assign fill_way_o  = fill_way_q;
    assign fill_data_o = mem_rsp_data_i;

    // Hit way in LOOKUP, fill way while filling
    assign touch_o     = fill_o || (in_lookup && hit_i);
    assign touch_way_o = fill_o ? fill_way_q : hit_way_i;

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_instr_o = rsp_instr_q;
    assign rsp_hit_o   = rsp_hit_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE:      if (take) state_d = icache_pkg::LOOKUP;
            icache_pkg::LOOKUP:    state_d = hit_i ? icache_pkg::RESPOND : icache_pkg::MISS_REQ;
            icache_pkg::MISS_REQ:  if (mem_req_o) state_d = icache_pkg::MISS_WAIT;
            icache_pkg::MISS_WAIT: if (mem_rsp_valid_i) state_d = icache_pkg::IDLE;
            icache_pkg::RESPOND:   state_d = icache_pkg::IDLE;
            default:               state_d = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= icache_pkg::IDLE;
            rsp_cred_q  <= `ICACHE_CRED_W'(`ICACHE_RSP_CREDITS);
            mem_cred_q  <= `ICACHE_CRED_W'(`ICACHE_MEM_CREDITS);
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_q <= (state_q == icache_pkg::RESPOND) || fill_o;   // Miss skips RESPOND
            case ({take, rsp_credit_i})                                  // Reserve at acceptance
                2'b10:   rsp_cred_q <= rsp_cred_q - `ICACHE_CRED_W'(1);
                2'b01:   rsp_cred_q <= rsp_cred_q + `ICACHE_CRED_W'(1);
                default: rsp_cred_q <= rsp_cred_q;
            endcase
            case ({mem_req_o, mem_credit_i})
                2'b10:   mem_cred_q <= mem_cred_q - `ICACHE_CRED_W'(1);
                2'b01:   mem_cred_q <= mem_cred_q + `ICACHE_CRED_W'(1);
                default: mem_cred_q <= mem_cred_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= req_addr_i;
        end
        if (in_lookup) begin
            rsp_instr_q <= hit_data_i;
            rsp_hit_q   <= hit_i;
            fill_way_q  <= has_free_i ? free_way_i : victim_way_i;   // Free way first
        end
        if (fill_o) begin
            rsp_instr_q <= mem_rsp_data_i;   // Forward the fill word
            rsp_hit_q   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_tag_array (
    input  logic               clk,
    input  logic               arst_n_i,
    input  icache_pkg::index_t index_i,
    input  icache_pkg::tag_t   tag_i,
    input  logic               fill_i,
    input  icache_pkg::way_t   fill_way_i,
    output logic               hit_o,
    output icache_pkg::way_t   hit_way_o,
    output logic               has_free_o,
    output icache_pkg::way_t   free_way_o
);

    icache_pkg::tag_t tag_q [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;

    // Walk from the top way down so the lowest match wins
    always_comb begin
        hit_o      = 1'b0;
        hit_way_o  = '0;
        has_free_o = 1'b0;
        free_way_o = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (valid_q[index_i][w] && (tag_q[index_i][w] == tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = icache_pkg::way_t'(w);
            end
            if (!valid_q[index_i][w]) begin
                has_free_o = 1'b1;
                free_way_o = icache_pkg::way_t'(w);   // Lowest invalid way
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[index_i][fill_way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[index_i][fill_way_i] <= tag_i;
        end
    end

endmodule

`default_nettype wire

//--- icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_data_array (
    input  logic                      clk,
    input  icache_pkg::index_t        index_i,
    input  icache_pkg::way_t          way_i,      // Hit way or fill way
    output logic [`ICACHE_DATA_W-1:0] rd_data_o,
    input  logic                      fill_i,
    input  logic [`ICACHE_DATA_W-1:0] fill_data_i
);

    logic [`ICACHE_DATA_W-1:0] word_q [`ICACHE_SETS][`ICACHE_WAYS];

    assign rd_data_o = word_q[index_i][way_i];   // Asynchronous read

    always_ff @(posedge clk) begin
        if (fill_i) begin
            word_q[index_i][way_i] <= fill_data_i;
        end
    end

endmodule

`default_nettype wire

//--- icache_lru.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_lru (
    input  logic               clk,
    input  logic               arst_n_i,
    input  icache_pkg::index_t index_i,
    input  logic               touch_i,
    input  icache_pkg::way_t   way_i,
    output icache_pkg::way_t   victim_way_o
);

    icache_pkg::age_t age_q [`ICACHE_SETS][`ICACHE_WAYS];
    icache_pkg::age_t touched_age;
    icache_pkg::age_t victim_age;

    assign touched_age = age_q[index_i][way_i];

    // Oldest way, lowest number on ties
    always_comb begin
        victim_way_o = '0;
        victim_age   = age_q[index_i][0];
        for (int w = 1; w < `ICACHE_WAYS; w++) begin
            if (age_q[index_i][w] > victim_age) begin
                victim_way_o = icache_pkg::way_t'(w);
                victim_age   = age_q[index_i][w];
            end
        end
    end

    // Ways equal to the old age also age, so a cleared set sorts itself into
    // distinct ages once every way has been touched
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (icache_pkg::way_t'(w) == way_i) begin
                    age_q[index_i][w] <= '0;                           // Most recent
                end else if ((age_q[index_i][w] <= touched_age) && !(&age_q[index_i][w])) begin
                    age_q[index_i][w] <= age_q[index_i][w] + icache_pkg::age_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      req_valid_i,
    input  icache_pkg::addr_u         req_addr_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output logic [`ICACHE_DATA_W-1:0] rsp_instr_o,
    output logic                      rsp_hit_o,
    input  logic                      rsp_credit_i,
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    input  logic                      mem_rsp_valid_i,
    input  logic [`ICACHE_DATA_W-1:0] mem_rsp_data_i,
    input  logic                      mem_credit_i
);

    icache_pkg::index_t        lkp_index;
    icache_pkg::tag_t          lkp_tag;
    logic                      hit;
    icache_pkg::way_t          hit_way;
    logic                      has_free;
    icache_pkg::way_t          free_way;
    logic [`ICACHE_DATA_W-1:0] hit_data;
    icache_pkg::way_t          victim_way;
    logic                      fill;
    icache_pkg::way_t          fill_way;
    logic [`ICACHE_DATA_W-1:0] fill_data;
    logic                      touch;
    icache_pkg::way_t          touch_way;    // Also the data array way

    icache_ctrl icache_ctrl_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_instr_o     (rsp_instr_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_credit_i    (rsp_credit_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_credit_i    (mem_credit_i),
        .lkp_index_o     (lkp_index),
        .lkp_tag_o       (lkp_tag),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .has_free_i      (has_free),
        .free_way_i      (free_way),
        .hit_data_i      (hit_data),
        .victim_way_i    (victim_way),
        .fill_o          (fill),
        .fill_way_o      (fill_way),
        .fill_data_o     (fill_data),
        .touch_o         (touch),
        .touch_way_o     (touch_way)
    );

    icache_tag_array icache_tag_array_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .index_i    (lkp_index),
        .tag_i      (lkp_tag),
        .fill_i     (fill),
        .fill_way_i (fill_way),
        .hit_o      (hit),
        .hit_way_o  (hit_way),
        .has_free_o (has_free),
        .free_way_o (free_way)
    );

    icache_data_array icache_data_array_inst (
        .clk         (clk),
        .index_i     (lkp_index),
        .way_i       (touch_way),
        .rd_data_o   (hit_data),
        .fill_i      (fill),
        .fill_data_i (fill_data)
    );

    icache_lru icache_lru_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .index_i      (lkp_index),
        .touch_i      (touch),
        .way_i        (touch_way),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

//--- icache_assert.sv
`timescale 1ns/10ps
`default_nettype none

module icache_assert (
    input wire logic clk,
    input wire logic arst_n_i,
    input wire logic req_ready_o,
    input wire logic rsp_valid_o,
    input wire logic mem_req_o,
    input wire logic mem_rsp_valid_i
);

    logic mem_pending_q;    // Read sent, answer not yet seen

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_pending_q <= 1'b0;
        end else if (mem_req_o) begin
            mem_pending_q <= 1'b1;
        end else if (mem_rsp_valid_i) begin
            mem_pending_q <= 1'b0;
        end
    end

    rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o |=> !rsp_valid_o)
        else $error("rsp_valid_o held for more than one cycle");

    mem_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_pending_q |-> !mem_req_o)
        else $error("mem_req_o raised again before mem_rsp_valid_i");

    ready_in_reset: assert property (@(posedge clk) !arst_n_i |-> !req_ready_o)
        else $error("req_ready_o high during reset");

endmodule

bind icache_top icache_assert icache_assert_inst (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i)
);

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module tb_icache;

    localparam int NUM_ENTRIES = 18;
    localparam int NUM_REPLAY  = 4;     // Entries fetched again after the second reset

    logic              clk;
    logic              arst_n_i;
    logic              req_valid_i;
    icache_pkg::addr_u req_addr_i;
    logic              req_ready_o;
    logic              rsp_valid_o;
    logic [31:0]       rsp_instr_o;
    logic              rsp_hit_o;
    logic              rsp_credit_i;
    logic              mem_req_o;
    logic [31:0]       mem_addr_o;
    logic              mem_rsp_valid_i;
    logic [31:0]       mem_rsp_data_i;
    logic              mem_credit_i;

    logic [31:0] stim [0:3*NUM_ENTRIES-1];
    logic [25:0] ref_tag [16][4];
    logic        ref_valid [16][4];
    logic [1:0]  ref_age [16][4];
    logic [31:0] exp_addr_q [$];
    logic        exp_hit_q [$];
    int          exp_dly_q [$];
    int          credit_due_q [$];
    logic [31:0] last_addr;
    int          cur_lat;
    int          cycle;
    int          mem_cnt;
    int          mem_reqs;
    int          outstanding;
    int          last_due;
    int          extra_dly;
    int          acc_count;
    int          rsp_count;
    int          limit;
    integer      seed;
    logic        mem_busy;
    logic [31:0] mem_hold;
    logic        load_done;

    icache_top icache_top_inst (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_instr_o     (rsp_instr_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_credit_i    (rsp_credit_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_credit_i    (mem_credit_i)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic void clear_model();
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_age[s][w]   = 2'd0;
            end
        end
    endfunction

    // Looks up and updates the reference cache, returns the predicted hit
    function automatic logic access_model(input logic [31:0] a);
        logic [3:0] idx;
        logic [1:0] old_age;
        logic       hit;
        logic       found;
        int         way;
        idx   = a[5:2];
        hit   = 1'b0;
        found = 1'b0;
        way   = 0;
        for (int w = 0; w < 4; w++) begin
            if (!hit && ref_valid[idx][w] && ref_tag[idx][w] == a[31:6]) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < 4; w++) begin
                if (!found && !ref_valid[idx][w]) begin
                    found = 1'b1;
                    way   = w;
                end
            end
            if (!found) begin
                for (int w = 1; w < 4; w++) begin
                    if (ref_age[idx][w] > ref_age[idx][way]) way = w;   // Oldest, lowest on ties
                end
            end
            ref_tag[idx][way]   = a[31:6];
            ref_valid[idx][way] = 1'b1;
        end
        old_age = ref_age[idx][way];
        for (int w = 0; w < 4; w++) begin
            if (w == way) begin
                ref_age[idx][w] = 2'd0;
            end else if (ref_age[idx][w] <= old_age && ref_age[idx][w] != 2'd3) begin
                ref_age[idx][w] = ref_age[idx][w] + 2'd1;
            end
        end
        return hit;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_fetch(input int e);
        req_valid_i    = 1'b1;
        req_addr_i.raw = stim[3*e];
        while (!req_ready_o) @(negedge clk);
        @(posedge clk);                      // Accepted here
        exp_addr_q.push_back(stim[3*e]);
        exp_hit_q.push_back(access_model(stim[3*e]));
        exp_dly_q.push_back(int'(stim[3*e+2]));
        last_addr = stim[3*e];
        cur_lat   = int'(stim[3*e+1]);
        acc_count++;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        exp_addr_q.delete();
        exp_hit_q.delete();
        exp_dly_q.delete();
        clear_model();
        repeat (5) begin
            @(negedge clk);
            check_value("req_ready_o", 32'd0, 32'(req_ready_o));
        end
        arst_n_i = 1'b1;
        @(negedge clk);
        check_value("req_ready_o", 32'd1, 32'(req_ready_o));
    endtask

    // Memory model, response monitor and credit return
    always @(negedge clk) begin
        cycle++;
        mem_rsp_valid_i = 1'b0;
        mem_credit_i    = 1'b0;
        rsp_credit_i    = 1'b0;
        if (!arst_n_i) begin
            credit_due_q.delete();
            mem_busy    = 1'b0;
            mem_reqs    = 0;
            outstanding = 0;
            last_due    = 0;
        end else begin
            if (mem_busy) begin
                if (mem_cnt <= 1) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_credit_i    = 1'b1;          // Credit comes back with the data
                    mem_rsp_data_i  = mem_hold ^ 32'h5A5A_0000;
                    mem_busy        = 1'b0;
                end else begin
                    mem_cnt--;
                end
            end else if (mem_req_o) begin
                check_value("mem_addr_o", last_addr, mem_addr_o);
                mem_busy = 1'b1;
                mem_hold = mem_addr_o;
                mem_cnt  = cur_lat;
                mem_reqs++;
            end
            if (credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
                void'(credit_due_q.pop_front());
                rsp_credit_i = 1'b1;
                outstanding--;
            end
            if (rsp_valid_o) begin
                if (exp_addr_q.size() == 0) begin
                    $display("A response arrived with no request waiting for it");
                    $display("Test failed");
                    $fatal(1);
                end
                check_value("rsp_hit_o", 32'(exp_hit_q[0]), 32'(rsp_hit_o));
                check_value("rsp_instr_o", exp_addr_q[0] ^ 32'h5A5A_0000, rsp_instr_o);
                check_value("mem_req_o count", exp_hit_q[0] ? 32'd0 : 32'd1, 32'(mem_reqs));
                mem_reqs = 0;
                outstanding++;
                check_value("rsp credit bound", 32'd1,
                            32'(outstanding <= `ICACHE_RSP_CREDITS));
                extra_dly = int'($unsigned($random(seed)) % 4);
                last_due  = (cycle + exp_dly_q[0] + extra_dly > last_due)
                          ? cycle + exp_dly_q[0] + extra_dly
                          : last_due + 1;
                credit_due_q.push_back(last_due);
                void'(exp_addr_q.pop_front());
                void'(exp_hit_q.pop_front());
                void'(exp_dly_q.pop_front());
                rsp_count++;
            end
        end
    end

    initial begin
        wait (load_done);
        limit = 0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            limit += int'(stim[3*e+1]) + int'(stim[3*e+2]) + 50;
        end
        limit += 50 * (NUM_REPLAY + 2);              // Replay and both resets
        repeat (limit) @(posedge clk);
        $display("Timeout: the cache stopped answering before all fetches were done");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        seed = 31;
        clk = 1'b0;
        arst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        rsp_credit_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i = '0;
        mem_credit_i = 1'b0;
        cycle = 0;
        acc_count = 0;
        rsp_count = 0;
        cur_lat = 1;
        last_addr = '0;
        $readmemh("icache_stim.txt", stim);
        load_done = 1'b1;
        apply_reset();
        for (int e = 0; e < NUM_ENTRIES; e++) send_fetch(e);
        while (rsp_count != acc_count) @(negedge clk);
        apply_reset();                               // Cache must come back empty
        for (int e = 0; e < NUM_REPLAY; e++) send_fetch(e);
        while (rsp_count != acc_count) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_stim.txt
// One fetch per line: fetch address, memory latency in cycles, response-credit delay in cycles
// All values hex; set index is address bits 5:2
0000100C 3 1
00002010 5 1
0000100C 2 1
00002010 2 0
0000200C 1 2
0000300C 7 1
0000100C 2 0
0000400C 4 3
0000200C 2 1
0000500C 6 0
0000300C 3 2
0000100C 2 1
0000400C 5 0
00000040 2 28
00000044 4 28
00000040 1 28
00003010 9 2
00002010 3 0

//--- sources.f
+incdir+.
icache_pkg.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_top.sv
icache_assert.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_icache -Mdir obj_dir

./obj_dir/Vtb_icache | tee sim.log || true

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0
